// File: compile.f
+incdir+verification
hdl/cordic_fmt_pkg.sv
hdl/cordic_ctrl_pkg.sv
hdl/cordic_atan_rom.sv
hdl/cordic_seq_fsm.sv
hdl/cordic_prep_stage.sv
hdl/cordic_update_stage.sv
hdl/cordic_out_stage.sv
hdl/cordic_sincos.sv
verification/cordic_sincos_tb.sv

// File: Makefile
# Verilator build and run for the CORDIC sine/cosine engine

VERILATOR ?= verilator
TOP       ?= cordic_sincos_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/cordic_model.svh
`ifndef CORDIC_MODEL_SVH
`define CORDIC_MODEL_SVH

// ====================
// Reference model
// ====================

// Nearest Q2.FRAC_W value, inputs here are never negative
function automatic coord_t to_fixed(input real v);
    return coord_t'($rtoi(v * (2.0 ** FRAC_W) + 0.5));
endfunction

function automatic coord_t atan_fixed(input int i);
    return to_fixed($atan(1.0 / (2.0 ** i)));               // atan(2^-i)
endfunction

// Rotation mode, X and Y both step from the pre-iteration values
function automatic xyz_t rotate_to_angle(input coord_t a, input int n_iter);
    coord_t x;
    coord_t y;
    coord_t z;
    coord_t x_sh;
    coord_t y_sh;
    x = to_fixed(0.607252935);                              // Gain folded into start X
    y = '0;
    z = a;
    for (int i = 0; i < n_iter; i++)
    begin
        x_sh = x >>> i;
        y_sh = y >>> i;
        if (z >= 0)
        begin
            x = x - y_sh;                                   // Turn counterclockwise
            y = y + x_sh;
            z = z - atan_fixed(i);
        end
        else
        begin
            x = x + y_sh;
            y = y - x_sh;
            z = z + atan_fixed(i);
        end
    end
    return '{x: x, y: y, z: z};
endfunction

// True angle is a + region * pi/2
function automatic coord_t correct_quadrant(input xyz_t v, input region_t rg, input logic s);
    case (rg)
        2'd0:    return s ? v.y : v.x;
        2'd1:    return s ? v.x : coord_t'(-v.y);
        2'd2:    return s ? coord_t'(-v.y) : coord_t'(-v.x);
        default: return s ? coord_t'(-v.x) : v.y;
    endcase
endfunction

function automatic coord_t expected_result(input coord_t a, input region_t rg, input logic s,
                                           input int n_iter);
    return correct_quadrant(rotate_to_angle(a, n_iter), rg, s);
endfunction

`endif

// File: verification/cordic_sincos_tb.sv
`timescale 1ns/1ns

module cordic_sincos_tb
    import cordic_fmt_pkg::*;
();

    localparam int ITERS_LOG2  = 4;                         // 16 iterations
    localparam int N_ITER      = 2 ** ITERS_LOG2;
    localparam int LATENCY     = 2 + 5 * N_ITER;            // Start edge to ready high
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DLY   = 10;                        // Inputs move after the edge
    localparam int N_RANDOM    = 200;
    localparam int N_DIRECTED  = 24;                        // 3 angles, 4 regions, 2 functions
    localparam int MAX_HOLD    = 7;                         // Longest ack stall
    localparam int MARGIN      = 20;
    localparam int WATCHDOG_NS = (N_RANDOM + N_DIRECTED) * (LATENCY + MAX_HOLD + MARGIN)
                                 * CLK_PERIOD + 50 * CLK_PERIOD;

    logic       clk;
    logic       rst_n;
    logic       start;
    logic       ack;
    logic       want_sin;
    coord_t     angle;
    region_t    region;
    logic       ready;
    coord_t     result;

    int         seed;

    `include "cordic_model.svh"

    cordic_sincos #(
        .WORD_W    (WORD_W),
        .FRAC_W    (FRAC_W),
        .ITER_BITS (ITERS_LOG2)
    ) cordic_sincos_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .ack      (ack),
        .want_sin (want_sin),
        .angle    (angle),
        .region   (region),
        .ready    (ready),
        .result   (result)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ====================
    // Failure reporting
    // ====================
    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1, "Stopped at the first failing check");
    endtask

    task automatic mismatch_error(input string test, input logic signed [31:0] expected,
                                  input logic signed [31:0] actual);
        $display("** Error: %s expected %0d actual %0d", test, expected, actual);
        abort_run();
    endtask

    task automatic protocol_error(input string what);
        $display("Error: %s", what);
        abort_run();
    endtask

    task automatic next_drive_point();
        @(posedge clk);
        #DRIVE_DLY;                                         // Outputs settled, safe to drive
    endtask

    // ====================
    // One transaction
    // ====================
    task automatic run_request(input string test, input coord_t a, input region_t rg,
                               input logic s, input int hold, input logic poke);
        coord_t exp;
        int     cycles;
        exp      = expected_result(a, rg, s, N_ITER);
        start    = 1'b1;
        angle    = a;
        region   = rg;
        want_sin = s;
        next_drive_point();                                 // Start sampled in IDLE
        start  = 1'b0;
        cycles = 0;
        while (ready !== 1'b1)
        begin
            if (poke && cycles == 10)
            begin
                start    = 1'b1;                            // Ignored while busy
                angle    = ~a;
                region   = ~rg;
                want_sin = ~s;
            end
            else
                start = 1'b0;
            if (cycles > LATENCY + MARGIN)
                protocol_error($sformatf("%s: ready never rose", test));
            next_drive_point();
            cycles++;
        end
        assert (cycles == LATENCY) else mismatch_error({test, " latency"}, LATENCY, cycles);
        assert (result === exp) else mismatch_error({test, " result"}, exp, result);
        repeat (hold)
        begin
            next_drive_point();                             // Back-pressure, ack low
            assert (ready === 1'b1) else protocol_error({test, ": ready dropped without ack"});
            assert (result === exp) else mismatch_error({test, " held result"}, exp, result);
        end
        ack = 1'b1;
        next_drive_point();
        ack = 1'b0;
        assert (ready === 1'b0) else protocol_error({test, ": ready stayed high after ack"});
    endtask

    // ====================
    // Main sequence
    // ====================
    initial
    begin
        int      r;
        int      hold;
        coord_t  pi4;
        coord_t  a;
        region_t rg;
        logic    fn;
        seed        = 32'h1c5c50a8;
        rst_n       = 1'b0;
        start       = 1'b0;
        ack         = 1'b0;
        want_sin    = 1'b0;
        angle       = '0;
        region      = '0;
        pi4         = to_fixed(3.141592653589793 / 4.0);
        repeat (4) @(posedge clk);
        #DRIVE_DLY rst_n = 1'b1;
        for (int i = 0; i < 8; i++)
        begin
            next_drive_point();
            assert (ready === 1'b0) else protocol_error("ready rose with no start");
        end
        for (int d = 0; d < 3; d++)
        begin
            a = (d == 0) ? coord_t'(0) : ((d == 1) ? pi4 : coord_t'(-pi4));  // 0, +pi/4, -pi/4
            for (int g = 0; g < 4; g++)
            begin
                for (int f = 0; f < 2; f++)
                begin
                    run_request($sformatf("directed a=%0d r=%0d sin=%0d", a, g, f),
                                a, region_t'(g), f[0], 0, 1'b0);
                end
            end
        end
        for (int n = 0; n < N_RANDOM; n++)
        begin
            r    = $random(seed);
            a    = coord_t'(r % (pi4 + 1));                 // Within [-pi/4, pi/4]
            rg   = region_t'($random(seed) & 3);
            fn   = 1'($random(seed) & 1);
            hold = $random(seed) & MAX_HOLD;
            run_request($sformatf("random %0d", n), a, rg, fn, hold, (n % 3 == 0));
        end
        $display("Finished with no errors");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        protocol_error("watchdog expired, the DUT stopped answering");
    end

endmodule

// File: hdl/cordic_sincos.sv
`timescale 1ns/1ns

module cordic_sincos
    import cordic_fmt_pkg::*;
    import cordic_ctrl_pkg::*;
#(
    parameter int WORD_W    = cordic_fmt_pkg::WORD_W,
    parameter int FRAC_W    = cordic_fmt_pkg::FRAC_W,
    parameter int ITER_BITS = cordic_fmt_pkg::ITER_BITS
)
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start,                                  // Begin a computation
    input  logic    ack,                                    // Result consumed
    input  logic    want_sin,                               // 1 sine, 0 cosine
    input  coord_t  angle,                                  // Q2.30, |angle| <= pi/4
    input  region_t region,
    output logic    ready,
    output coord_t  result
);

    stage_en_t en;
    iter_t     iter;
    logic      update_done;
    req_t      req_in;
    req_t      req_q;
    xyz_t      xyz_cur;
    xyz_t      xyz_new;
    prep_t     prep;

    assign req_in = '{angle: angle, region: region, want_sin: want_sin};

    // ====================
    // Sequencer
    // ====================
    cordic_seq_fsm #(
        .ITER_BITS (ITER_BITS)
    ) seq_fsm_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .ack         (ack),
        .update_done (update_done),
        .en          (en),
        .iter        (iter),
        .ready       (ready)
    );

    // ====================
    // Datapath
    // ====================
    cordic_prep_stage #(
        .WORD_W (WORD_W),
        .FRAC_W (FRAC_W)
    ) prep_stage_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .iter    (iter),
        .req_in  (req_in),
        .xyz_fb  (xyz_new),                                 // Loop back each iteration
        .req_q   (req_q),
        .xyz_cur (xyz_cur),
        .prep    (prep)
    );

    cordic_update_stage update_stage_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .update_go   (en.update_go),
        .xyz_cur     (xyz_cur),
        .prep        (prep),
        .xyz_new     (xyz_new),
        .update_done (update_done)
    );

    cordic_out_stage out_stage_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .out_en (en.out_en),
        .req_q  (req_q),
        .xyz    (xyz_new),
        .result (result)
    );

endmodule

// File: hdl/cordic_out_stage.sv
`timescale 1ns/1ns

module cordic_out_stage
    import cordic_fmt_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   out_en,                                  // Load final value
    input  req_t   req_q,                                   // Region and function
    input  xyz_t   xyz,                                     // Final X, Y
    output coord_t result
);

    logic   use_y;                                          // Y track selected
    logic   negate;
    coord_t pick;
    coord_t fixed;

    // ====================
    // Quadrant correction
    // ====================
    // sin picks y on even regions, cos on odd ones
    assign use_y  = req_q.want_sin ^ req_q.region[0];
    // sin flips in regions 2,3, cos in 1,2
    assign negate = req_q.region[1] ^ (~req_q.want_sin & req_q.region[0]);
    assign pick   = use_y ? xyz.y : xyz.x;
    assign fixed  = negate ? coord_t'(-pick) : pick;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            result <= '0;
        else if (out_en)
            result <= fixed;                                // Held until next angle
    end

    a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !out_en |=> $stable(result))
        else $error("result moved without out_en");

endmodule

// File: hdl/cordic_update_stage.sv
`timescale 1ns/1ns

module cordic_update_stage
    import cordic_fmt_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   update_go,                               // Starts the three passes
    input  xyz_t   xyz_cur,                                 // Pre-iteration values
    input  prep_t  prep,
    output xyz_t   xyz_new,                                 // Post-iteration values
    output logic   update_done                              // High in the Z write cycle
);

    logic [1:0] step_q;                                     // 0 X, 1 Y, 2 Z
    logic       busy_q;
    logic       active;
    logic       sub;                                        // Adder subtracts
    coord_t     opa;
    coord_t     opb;
    coord_t     sum;

    assign active      = update_go || busy_q;
    assign update_done = busy_q && (step_q == 2'd2);

    // ====================
    // Operand select
    // ====================
    always_comb
    begin
        case (step_q)
            2'd0:
            begin
                opa = xyz_cur.x;
                opb = prep.y_sh;
                sub = prep.dir;                             // X -/+ Y>>i
            end
            2'd1:
            begin
                opa = xyz_cur.y;
                opb = prep.x_sh;
                sub = ~prep.dir;                            // Y +/- X>>i
            end
            default:
            begin
                opa = xyz_cur.z;
                opb = prep.atan;
                sub = prep.dir;                             // Z -/+ atan
            end
        endcase
    end

    assign sum = sub ? coord_t'(opa - opb) : coord_t'(opa + opb);  // Shared adder

    // ====================
    // Step control
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            step_q <= 2'd0;
            busy_q <= 1'b0;
        end
        else if (active)
        begin
            step_q <= (step_q == 2'd2) ? 2'd0 : step_q + 2'd1;
            busy_q <= (step_q != 2'd2);                     // Idle after Z
        end
    end

    always_ff @(posedge clk)
    begin
        if (active)
        begin
            case (step_q)
                2'd0:    xyz_new.x <= sum;
                2'd1:    xyz_new.y <= sum;
                default: xyz_new.z <= sum;
            endcase
        end
    end

    a_step_range: assert property (@(posedge clk) disable iff (!rst_n)
        update_go |-> ##2 (update_done && step_q != 2'd3))
        else $error("Update sequence lost its step");

endmodule

// File: hdl/cordic_prep_stage.sv
`timescale 1ns/1ns

module cordic_prep_stage
    import cordic_fmt_pkg::*;
    import cordic_ctrl_pkg::*;
#(
    parameter int WORD_W = cordic_fmt_pkg::WORD_W,
    parameter int FRAC_W = cordic_fmt_pkg::FRAC_W
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  stage_en_t en,
    input  iter_t     iter,
    input  req_t      req_in,                               // From the top level ports
    input  xyz_t      xyz_fb,                               // Update stage results
    output req_t      req_q,                                // Held request
    output xyz_t      xyz_cur,                              // Pre-iteration X, Y, Z
    output prep_t     prep                                  // Adder operands and dir
);

    coord_t atan_rom;                                       // ROM output for iter
    xyz_t   xyz_start;                                      // Iteration 0 values

    cordic_atan_rom #(
        .WORD_W (WORD_W),
        .FRAC_W (FRAC_W)
    ) atan_rom_inst (
        .iter (iter),
        .atan (atan_rom)
    );

    // Gain preloaded into X, Y from zero, Z holds the angle
    assign xyz_start = '{x: CORDIC_K, y: coord_t'(0), z: req_q.angle};

    // ====================
    // Request capture
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            req_q <= '0;
        else if (en.load_en)
            req_q <= req_in;                                // Held through DONE
    end

    // ====================
    // Working values
    // ====================
    always_ff @(posedge clk)
    begin
        if (en.prep_en)
            xyz_cur <= (iter == '0) ? xyz_start : xyz_fb;   // Fresh start or feedback
    end

    always_ff @(posedge clk)
    begin
        if (en.shift_en)
        begin
            prep.x_sh <= $signed(xyz_cur.x) >>> iter;       // Sign-filling shift
            prep.y_sh <= $signed(xyz_cur.y) >>> iter;
            prep.atan <= atan_rom;
            prep.dir  <= ~xyz_cur.z[WORD_W-1];              // Rotate toward Z = 0
        end
    end

endmodule

// File: hdl/cordic_seq_fsm.sv
`timescale 1ns/1ns

module cordic_seq_fsm
    import cordic_fmt_pkg::*;
    import cordic_ctrl_pkg::*;
#(
    parameter int ITER_BITS = cordic_fmt_pkg::ITER_BITS
)
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      start,                                // Sampled in IDLE only
    input  logic      ack,                                  // Consumer took the result
    input  logic      update_done,                          // Z write cycle of UPDATE
    output stage_en_t en,                                   // Stage enables
    output iter_t     iter,                                 // Current iteration
    output logic      ready                                 // Result valid
);

    localparam iter_t LAST_ITER = iter_t'((2 ** ITER_BITS) - 1);

    seq_state_t state_q;
    iter_t      iter_q;
    logic       upd_first_q;                                // First UPDATE cycle
    logic       ready_q;
    logic       last_iter;

    assign last_iter = (iter_q == LAST_ITER);
    assign iter      = iter_q;
    assign ready     = ready_q;

    // ====================
    // State and counter
    // ====================
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q     <= IDLE;
            iter_q      <= '0;
            upd_first_q <= 1'b0;
            ready_q     <= 1'b0;
        end
        else
        begin
            upd_first_q <= (state_q == SHIFT);              // Marks the UPDATE entry
            case (state_q)
                IDLE:
                begin
                    if (start)
                        state_q <= LOAD;                    // Busy from here on
                end
                LOAD:
                begin
                    iter_q  <= '0;                          // Fresh count per angle
                    state_q <= PREP;
                end
                PREP:
                    state_q <= SHIFT;
                SHIFT:
                    state_q <= UPDATE;
                UPDATE:
                begin
                    if (update_done && last_iter)
                        state_q <= DONE;                    // Result loads on this edge
                    else if (update_done)
                    begin
                        iter_q  <= iter_q + 1'b1;
                        state_q <= PREP;
                    end
                end
                DONE:
                begin
                    if (!ready_q)
                        ready_q <= 1'b1;                    // Result settled one cycle
                    else if (ack)
                    begin
                        ready_q <= 1'b0;
                        state_q <= IDLE;
                    end
                end
                default:
                    state_q <= IDLE;
            endcase
        end
    end

    // ====================
    // Enable decode
    // ====================
    always_comb
    begin
        en           = '0;
        en.load_en   = (state_q == LOAD);
        en.prep_en   = (state_q == PREP);
        en.shift_en  = (state_q == SHIFT);
        en.update_go = (state_q == UPDATE) && upd_first_q;  // One pulse per iteration
        en.out_en    = (state_q == UPDATE) && update_done && last_iter;
    end

    a_en_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(en))
        else $error("Stage enables overlap");

    a_ready_done: assert property (@(posedge clk) disable iff (!rst_n)
        ready_q |-> (state_q == DONE))
        else $error("ready high outside DONE");

endmodule

// File: hdl/cordic_atan_rom.sv
`timescale 1ns/1ns

module cordic_atan_rom
    import cordic_fmt_pkg::*;
#(
    parameter int WORD_W = cordic_fmt_pkg::WORD_W,
    parameter int FRAC_W = cordic_fmt_pkg::FRAC_W
)
(
    input  iter_t  iter,                                    // Table address
    output coord_t atan                                     // atan(2^-iter), Q2.FRAC_W
);

    // Rounded to nearest at elaboration
    function automatic logic signed [WORD_W-1:0] atan_fix(input int idx);
        real ang;
        ang = $atan(1.0 / (2.0 ** idx));
        return WORD_W'($rtoi(ang * (2.0 ** FRAC_W) + 0.5));
    endfunction

    logic signed [WORD_W-1:0] table_w [ATAN_DEPTH];         // Constant table

    // ====================
    // Table contents
    // ====================
    for (genvar i = 0; i < ATAN_DEPTH; i++)
    begin : g_entry
        localparam logic signed [WORD_W-1:0] ENTRY = atan_fix(i);
        assign table_w[i] = ENTRY;                          // Fixed per entry
    end

    // Only the first 2^ITER_BITS entries are reachable
    assign atan = coord_t'(table_w[iter]);

endmodule

// File: hdl/cordic_ctrl_pkg.sv
package cordic_ctrl_pkg;

    // ====================
    // Sequencer states
    // ====================
    typedef enum logic [2:0] {
        IDLE,                                               // Waiting for start
        LOAD,                                               // Capture request
        PREP,                                               // Latch working X, Y, Z
        SHIFT,                                              // Shifts, ROM, direction
        UPDATE,                                             // Three adder passes
        DONE                                                // Result held until ack
    } seq_state_t;

    // ====================
    // Stage enables
    // ====================
    // At most one bit is high in any cycle
    typedef struct packed {
        logic load_en;                                      // Request register
        logic prep_en;                                      // Working X, Y, Z latch
        logic shift_en;                                     // Shift/ROM/dir register
        logic update_go;                                    // Kicks the adder sequence
        logic out_en;                                       // Result register
    } stage_en_t;

endpackage

// File: hdl/cordic_fmt_pkg.sv
package cordic_fmt_pkg;

    // ====================
    // Number format
    // ====================
    localparam int WORD_W     = 32;                         // Word width of X, Y, Z
    localparam int FRAC_W     = 30;                         // Fraction bits, Q2.30
    localparam int ITER_BITS  = 4;                          // 16 iterations, 5 at most
    localparam int ATAN_DEPTH = 32;                         // Arctangent table entries

    typedef logic signed [WORD_W-1:0] coord_t;              // Fixed-point coordinate
    typedef logic [ITER_BITS-1:0]     iter_t;               // Iteration index
    typedef logic [1:0]               region_t;             // Quadrant, angle + region*pi/2

    // ====================
    // Bundles
    // ====================
    typedef struct packed {
        coord_t x;                                          // Cosine track
        coord_t y;                                          // Sine track
        coord_t z;                                          // Residual angle
    } xyz_t;

    typedef struct packed {
        coord_t  angle;                                     // Reduced angle, |a| <= pi/4
        region_t region;
        logic    want_sin;                                  // 1 sine, 0 cosine
    } req_t;

    typedef struct packed {
        coord_t x_sh;                                       // X >>> i
        coord_t y_sh;                                       // Y >>> i
        coord_t atan;                                       // atan(2^-i)
        logic   dir;                                        // 1 rotates positive
    } prep_t;

    // Start X absorbs the CORDIC gain, 0.607252935 in Q2.30
    localparam coord_t CORDIC_K = 32'sh26DD3B6A;

endpackage
